// ==== compile.f ====
logic/pe_ctrl_pkg.sv
logic/temporal_map.sv
logic/rf_buffer_tracker.sv
logic/psum_bank_tracker.sv
logic/schedule_fsm.sv
logic/pe_array_controller.sv
testbench/tb_pe_array_controller.sv

// ==== testbench/tb_pe_array_controller.sv ====
// simulation top for the pe array controller with gbf and su adder responders and a reference model
`timescale 1ns/1ps

module tb_pe_array_controller;

    logic                       clk = 1'b0;
    logic                       reset;
    logic                       cfg_wr;
    pe_ctrl_pkg::cfg_write_t    cfg;
    logic                       layer_start;
    logic                       finish;
    logic                       su_done;
    pe_ctrl_pkg::gbf_sent_t     sent;
    pe_ctrl_pkg::rf_need_t      need;
    pe_ctrl_pkg::pe_ctrl_t      pe_ctrl;
    logic                       pe_psum_finish;
    logic                       conv_finish;

    // layer shape with tile lengths of 2, 4 and 8
    localparam pe_ctrl_pkg::tm_idx_t actv_last_m = 4'd1;
    localparam pe_ctrl_pkg::tm_idx_t wgt_last_m  = 4'd3;
    localparam pe_ctrl_pkg::tm_idx_t psum_last_m = 4'd7;
    localparam logic [pe_ctrl_pkg::pe_count-1:0] mac_mask_m = 16'ha5c3;

    logic [pe_ctrl_pkg::actv_addr_w-1:0] actv_tab_m [pe_ctrl_pkg::tm_depth];
    logic [pe_ctrl_pkg::wgt_addr_w-1:0]  wgt_tab_m  [pe_ctrl_pkg::tm_depth];
    logic [pe_ctrl_pkg::psum_addr_w-1:0] psum_tab_m [pe_ctrl_pkg::tm_depth];

    // reference model state
    int m_actv_cnt;
    int m_wgt_cnt;
    int m_psum_cnt;
    logic m_actv_sel;
    logic m_wgt_sel;
    logic m_psum_bank;
    pe_ctrl_pkg::pe_ctrl_t expect_ctrl;
    logic tile_hit;
    int issue_cnt = 0;
    int psum_ends = 0;
    int pulse_cnt = 0;
    logic last_end = 1'b0;
    logic finish_prev = 1'b0;
    string test_name = "reset";

    // one random stream per responder process
    logic [31:0] buf_rng = 32'd37086;
    logic [31:0] add_rng = 32'd37086 ^ 32'h9e3779b9;
    logic [31:0] tab_rng = 32'd37086 ^ 32'h85ebca6b;
    int buf_wait [4];
    int buf_hold;          // nonzero forces this refill delay
    int bi;
    int add_wait = 0;
    logic [3:0] need_prev = '0;
    logic [3:0] sent_next;

    pe_array_controller dut (
        .clk(clk), .reset(reset), .cfg_wr(cfg_wr), .cfg(cfg),
        .layer_start(layer_start), .finish(finish), .su_done(su_done), .sent(sent),
        .need(need), .pe_ctrl(pe_ctrl), .pe_psum_finish(pe_psum_finish),
        .conv_finish(conv_finish)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_ctrl(input string name, input pe_ctrl_pkg::pe_ctrl_t exp,
                              input pe_ctrl_pkg::pe_ctrl_t act);
        if (act !== exp) begin
            fail_stop($sformatf("Mismatch in %s: expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_need(input string name, input pe_ctrl_pkg::rf_need_t exp,
                              input pe_ctrl_pkg::rf_need_t act);
        if (act !== exp) begin
            fail_stop($sformatf("Mismatch in %s: expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_stop($sformatf("Mismatch in %s: expected %b actual %b", name, exp, act));
        end
    endtask

    // gbf model gives each rising need one sent pulse after a delay
    always @(posedge clk) begin
        sent_next = '0;
        if (reset) begin
            buf_wait = '{default: 0};
        end else begin
            for (bi = 0; bi < 4; bi++) begin
                if (need[bi] && !need_prev[bi]) begin
                    buf_rng = xorshift(buf_rng);
                    buf_wait[bi] = (buf_hold != 0) ? buf_hold : 1 + buf_rng % 6;
                end else if (buf_wait[bi] > 0) begin
                    buf_wait[bi]--;
                    if (buf_wait[bi] == 0) begin
                        sent_next[bi] = 1'b1;
                    end
                end
            end
        end
        need_prev <= need;
        sent <= sent_next;
    end

    // su adder drains the old bank some cycles after the hand-over
    always @(posedge clk) begin
        if (reset) begin
            add_wait = 0;
            su_done <= 1'b0;
        end else if (pe_psum_finish) begin
            add_rng = xorshift(add_rng);
            add_wait = 1 + add_rng % 6;
            su_done <= 1'b0;
        end else if (add_wait > 0) begin
            add_wait--;
            su_done <= (add_wait == 0);
        end else begin
            su_done <= 1'b0;
        end
    end

    // reference model and monitor where every nonzero pe_ctrl word counts as one issue
    always @(posedge clk) begin
        if (reset || layer_start) begin
            m_actv_cnt = 0;
            m_wgt_cnt = 0;
            m_psum_cnt = 0;
            m_actv_sel = 1'b0;
            m_wgt_sel = 1'b0;
            m_psum_bank = 1'b0;
            psum_ends <= 0;
            pulse_cnt <= 0;
        end else begin
            if (pe_ctrl != '0) begin
                expect_ctrl = '{mac_en: mac_mask_m, actv_sel: m_actv_sel,
                                actv_addr: actv_tab_m[m_actv_cnt], wgt_sel: m_wgt_sel,
                                wgt_addr: wgt_tab_m[m_wgt_cnt], psum_bank: m_psum_bank,
                                psum_addr: psum_tab_m[m_psum_cnt]};
                check_ctrl(test_name, expect_ctrl, pe_ctrl);
                issue_cnt <= issue_cnt + 1;
                tile_hit = 1'b0;
                if (m_actv_cnt == actv_last_m) begin
                    m_actv_cnt = 0;
                    m_actv_sel = ~m_actv_sel;  // next tile from the other buffer
                    tile_hit = 1'b1;
                end else begin
                    m_actv_cnt++;
                end
                if (m_wgt_cnt == wgt_last_m) begin
                    m_wgt_cnt = 0;
                    m_wgt_sel = ~m_wgt_sel;
                    tile_hit = 1'b1;
                end else begin
                    m_wgt_cnt++;
                end
                if (m_psum_cnt == psum_last_m) begin
                    m_psum_cnt = 0;
                    m_psum_bank = ~m_psum_bank;
                    tile_hit = 1'b1;
                    psum_ends <= psum_ends + 1;
                end else begin
                    m_psum_cnt++;
                end
                last_end <= tile_hit;
            end
            if (pe_psum_finish) begin
                if (finish_prev) begin
                    fail_stop($sformatf("pe_psum_finish high two cycles in %s", test_name));
                end
                if (pulse_cnt >= psum_ends) begin
                    fail_stop($sformatf("pe_psum_finish without a psum tile end in %s",
                                        test_name));
                end
                pulse_cnt <= pulse_cnt + 1;
            end
        end
        finish_prev <= pe_psum_finish;
    end

    task automatic wait_issue_count(input int target, input int limit);
        int n;
        n = 0;
        while (issue_cnt < target) begin
            @(posedge clk);
            n++;
            if (n > limit) begin
                fail_stop($sformatf("timeout in %s waiting for issue %0d", test_name, target));
            end
        end
    endtask

    // every psum tile end so far has to show up as one pe_psum_finish pulse
    task automatic wait_psum_pulses(input int limit);
        int n;
        n = 0;
        while (pulse_cnt != psum_ends) begin
            @(posedge clk);
            n++;
            if (n > limit) begin
                fail_stop($sformatf("timeout in %s waiting for one pe_psum_finish per psum tile",
                                    test_name));
            end
        end
    endtask

    task automatic write_cfg(input pe_ctrl_pkg::cfg_sel_e sel, input int index,
                             input logic [15:0] data);
        @(posedge clk);
        cfg_wr <= 1'b1;
        cfg <= '{sel: sel, index: pe_ctrl_pkg::tm_idx_t'(index), data: data};
    endtask

    task automatic load_config();
        int i;
        test_name = "config";
        write_cfg(pe_ctrl_pkg::cfg_tile_last, pe_ctrl_pkg::op_actv, 16'(actv_last_m));
        write_cfg(pe_ctrl_pkg::cfg_tile_last, pe_ctrl_pkg::op_wgt, 16'(wgt_last_m));
        write_cfg(pe_ctrl_pkg::cfg_tile_last, pe_ctrl_pkg::op_psum, 16'(psum_last_m));
        for (i = 0; i < pe_ctrl_pkg::tm_depth; i++) begin
            tab_rng = xorshift(tab_rng);
            actv_tab_m[i] = tab_rng[1:0];
            wgt_tab_m[i] = tab_rng[3:2];
            psum_tab_m[i] = tab_rng[5:4];
            write_cfg(pe_ctrl_pkg::cfg_actv_addr, i, 16'(actv_tab_m[i]));
            write_cfg(pe_ctrl_pkg::cfg_wgt_addr, i, 16'(wgt_tab_m[i]));
            write_cfg(pe_ctrl_pkg::cfg_psum_addr, i, 16'(psum_tab_m[i]));
        end
        write_cfg(pe_ctrl_pkg::cfg_mac_mask, 0, mac_mask_m);
        @(posedge clk);
        cfg_wr <= 1'b0;
    endtask

    task automatic reset_state_test();
        test_name = "reset";
        repeat (2) @(posedge clk);
        check_need("reset/need", '0, need);
        check_ctrl("reset/pe_ctrl", '0, pe_ctrl);
        check_bit("reset/pe_psum_finish", 1'b0, pe_psum_finish);
        check_bit("reset/conv_finish", 1'b0, conv_finish);
    endtask

    task automatic fill_test();
        int start;
        int n;
        test_name = "fill";
        @(posedge clk);
        buf_hold <= 10;
        layer_start <= 1'b1;
        @(posedge clk);
        layer_start <= 1'b0;
        @(posedge clk);
        check_need("fill/need all", pe_ctrl_pkg::rf_need_t'(4'hf), need);
        start = issue_cnt;
        repeat (6) @(posedge clk);
        check_bit("fill/no early issue", 1'b1, issue_cnt == start);
        n = 0;
        while (need.actv_need[0] || need.wgt_need[0]) begin
            @(posedge clk);
            n++;
            if (n > 30) begin
                fail_stop("timeout in fill waiting for buffer 0 of actv and wgt to load");
            end
        end
        check_bit("fill/no issue before load", 1'b1, issue_cnt == start);
        buf_hold <= 0;
        wait_issue_count(start + 1, 10);
    endtask

    task automatic mapping_test();
        test_name = "mapping";
        wait_issue_count(issue_cnt + 48, 400);
        wait_psum_pulses(40);
    endtask

    task automatic stall_test();
        int n;
        int c0;
        int c1;
        test_name = "stall";
        @(posedge clk);
        buf_hold <= 40;
        n = 0;
        while (need.actv_need != 2'b00) begin  // let pending refills land first
            @(posedge clk);
            n++;
            if (n > 60) begin
                fail_stop("timeout in stall waiting for both actv buffers to load");
            end
        end
        n = 0;
        while (need.actv_need == 2'b00) begin
            @(posedge clk);
            n++;
            if (n > 100) begin
                fail_stop("timeout in stall waiting for an actv buffer release");
            end
        end
        c0 = issue_cnt;
        repeat (20) @(posedge clk);
        c1 = issue_cnt;
        check_bit("stall/issues before stall", 1'b1, c1 - c0 <= 3);
        repeat (10) @(posedge clk);
        check_bit("stall/no issue while waiting", 1'b1, issue_cnt == c1);
        check_bit("stall/released need", 1'b1, need.actv_need != 2'b00);
        buf_hold <= 0;
        wait_issue_count(c1 + 24, 200);
        wait_psum_pulses(40);
    endtask

    task automatic finish_test();
        int n;
        int start;
        test_name = "finish";
        wait_issue_count(issue_cnt + 3, 50);
        finish <= 1'b1;
        @(posedge clk);
        finish <= 1'b0;
        n = 0;
        while (!conv_finish) begin
            @(posedge clk);
            n++;
            if (n > 60) begin
                fail_stop("timeout in finish waiting for conv_finish");
            end
        end
        @(posedge clk);  // last issue reaches the monitor here
        check_bit("finish/stop at tile end", 1'b1, last_end);
        start = issue_cnt;
        repeat (10) @(posedge clk);
        check_bit("finish/no issue after stop", 1'b1, issue_cnt == start);
        check_bit("finish/conv_finish held", 1'b1, conv_finish);
        layer_start <= 1'b1;
        @(posedge clk);
        layer_start <= 1'b0;
        @(posedge clk);
        check_bit("finish/conv_finish cleared", 1'b0, conv_finish);
        wait_issue_count(start + 16, 300);  // model restarts at counter 0 on buffer 0
    endtask

    initial begin
        reset = 1'b1;
        cfg_wr = 1'b0;
        cfg = '0;
        layer_start = 1'b0;
        finish = 1'b0;
        su_done = 1'b0;
        sent = '0;
        buf_hold = 0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        reset_state_test();
        load_config();
        fill_test();
        mapping_test();
        stall_test();
        finish_test();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== logic/pe_array_controller.sv ====
// top of the pe array controller, joins the mapping store, the trackers and the layer FSM
`timescale 1ns/1ps

module pe_array_controller (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cfg_wr,
    input  pe_ctrl_pkg::cfg_write_t cfg,
    input  logic                    layer_start,
    input  logic                    finish,
    input  logic                    su_done,
    input  pe_ctrl_pkg::gbf_sent_t  sent,
    output pe_ctrl_pkg::rf_need_t   need,
    output pe_ctrl_pkg::pe_ctrl_t   pe_ctrl,
    output logic                    pe_psum_finish,
    output logic                    conv_finish
);

    logic clear;
    logic advance;
    logic actv_swap;
    logic wgt_swap;
    logic psum_swap;
    logic fill_ready;

    pe_ctrl_pkg::tm_idx_t actv_count;
    pe_ctrl_pkg::tm_idx_t wgt_count;
    pe_ctrl_pkg::tm_idx_t psum_count;
    pe_ctrl_pkg::tm_idx_t actv_last;
    pe_ctrl_pkg::tm_idx_t wgt_last;
    pe_ctrl_pkg::tm_idx_t psum_last;

    logic actv_sel, actv_end, actv_ready;
    logic wgt_sel, wgt_end, wgt_ready;
    logic psum_bank, psum_end, psum_ready;
    logic [1:0] actv_rf_need;
    logic [1:0] wgt_rf_need;

    assign need = '{actv_need: actv_rf_need, wgt_need: wgt_rf_need};
    assign fill_ready = !actv_rf_need[0] && !wgt_rf_need[0];  // both buffer 0 loaded

    temporal_map u_map (
        .clk(clk), .reset(reset), .cfg_wr(cfg_wr), .cfg(cfg), .advance(advance),
        .actv_idx(actv_count), .wgt_idx(wgt_count), .psum_idx(psum_count),
        .actv_sel(actv_sel), .wgt_sel(wgt_sel), .psum_bank(psum_bank),
        .actv_last(actv_last), .wgt_last(wgt_last), .psum_last(psum_last),
        .pe_ctrl(pe_ctrl)
    );

    rf_buffer_tracker u_actv (
        .clk(clk), .reset(reset), .clear(clear), .advance(advance), .swap(actv_swap),
        .sent(sent.actv_sent), .tile_last(actv_last), .count(actv_count), .sel(actv_sel),
        .tile_end(actv_end), .swap_ready(actv_ready), .need(actv_rf_need)
    );

    rf_buffer_tracker u_wgt (
        .clk(clk), .reset(reset), .clear(clear), .advance(advance), .swap(wgt_swap),
        .sent(sent.wgt_sent), .tile_last(wgt_last), .count(wgt_count), .sel(wgt_sel),
        .tile_end(wgt_end), .swap_ready(wgt_ready), .need(wgt_rf_need)
    );

    psum_bank_tracker u_psum (
        .clk(clk), .reset(reset), .clear(clear), .advance(advance), .swap(psum_swap),
        .su_done(su_done), .tile_last(psum_last), .count(psum_count), .bank(psum_bank),
        .tile_end(psum_end), .swap_ready(psum_ready), .pe_psum_finish(pe_psum_finish)
    );

    schedule_fsm u_fsm (
        .clk(clk), .reset(reset), .layer_start(layer_start), .finish(finish),
        .actv_end(actv_end), .actv_ready(actv_ready),
        .wgt_end(wgt_end), .wgt_ready(wgt_ready),
        .psum_end(psum_end), .psum_ready(psum_ready),
        .fill_ready(fill_ready), .clear(clear), .advance(advance),
        .actv_swap(actv_swap), .wgt_swap(wgt_swap), .psum_swap(psum_swap),
        .conv_finish(conv_finish)
    );

endmodule

// ==== logic/schedule_fsm.sv ====
// layer FSM that issues mac cycles, stalls on missing refills or drains and swaps at tile ends
`timescale 1ns/1ps

module schedule_fsm (
    input  logic clk,
    input  logic reset,
    input  logic layer_start,
    input  logic finish,
    input  logic actv_end,
    input  logic actv_ready,
    input  logic wgt_end,
    input  logic wgt_ready,
    input  logic psum_end,
    input  logic psum_ready,
    input  logic fill_ready,
    output logic clear,
    output logic advance,
    output logic actv_swap,
    output logic wgt_swap,
    output logic psum_swap,
    output logic conv_finish
);

    pe_ctrl_pkg::sched_state_e state;
    pe_ctrl_pkg::sched_state_e state_next;

    logic finish_pend;  // finish seen, stop at the next tile boundary
    logic stop_now;
    logic any_end;
    logic all_ready;

    assign stop_now = finish_pend | finish;
    assign any_end  = actv_end | wgt_end | psum_end;

    // only operands whose tile ended have to be ready
    assign all_ready = (!actv_end || actv_ready) &&
                       (!wgt_end || wgt_ready) &&
                       (!psum_end || psum_ready);

    always_comb begin
        state_next = state;
        clear      = 1'b0;
        advance    = 1'b0;
        case (state)
            pe_ctrl_pkg::st_idle, pe_ctrl_pkg::st_done: begin
                if (layer_start) begin
                    state_next = pe_ctrl_pkg::st_fill;
                    clear      = 1'b1;
                end
            end
            pe_ctrl_pkg::st_fill: begin
                if (fill_ready) begin  // buffer 0 of actv and wgt both loaded
                    state_next = pe_ctrl_pkg::st_compute;
                end
            end
            pe_ctrl_pkg::st_compute: begin
                advance = 1'b1;  // every compute cycle is an issue
                if (any_end) begin
                    if (stop_now) begin
                        state_next = pe_ctrl_pkg::st_done;
                    end else if (all_ready) begin
                        state_next = pe_ctrl_pkg::st_swap;
                    end else begin
                        state_next = pe_ctrl_pkg::st_stall;
                    end
                end
            end
            pe_ctrl_pkg::st_stall: begin
                if (stop_now) begin
                    state_next = pe_ctrl_pkg::st_done;
                end else if (all_ready) begin
                    state_next = pe_ctrl_pkg::st_swap;
                end
            end
            pe_ctrl_pkg::st_swap: state_next = pe_ctrl_pkg::st_compute;
            default: state_next = pe_ctrl_pkg::st_idle;
        endcase
    end

    // tile_end stays high through the stall, so it still marks the operand here
    assign actv_swap = (state == pe_ctrl_pkg::st_swap) && actv_end;
    assign wgt_swap  = (state == pe_ctrl_pkg::st_swap) && wgt_end;
    assign psum_swap = (state == pe_ctrl_pkg::st_swap) && psum_end;

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= pe_ctrl_pkg::st_idle;
            finish_pend <= 1'b0;
            conv_finish <= 1'b0;
        end else begin
            state       <= state_next;
            conv_finish <= (state_next == pe_ctrl_pkg::st_done);
            if (clear) begin
                finish_pend <= 1'b0;
            end else if (finish) begin
                finish_pend <= 1'b1;
            end
        end
    end

endmodule

// ==== logic/psum_bank_tracker.sv ====
// psum bank ping-pong with drain status from the su adder and the tile counter for psum addresses
`timescale 1ns/1ps

module psum_bank_tracker (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 clear,
    input  logic                 advance,
    input  logic                 swap,
    input  logic                 su_done,
    input  pe_ctrl_pkg::tm_idx_t tile_last,
    output pe_ctrl_pkg::tm_idx_t count,
    output logic                 bank,
    output logic                 tile_end,
    output logic                 swap_ready,
    output logic                 pe_psum_finish
);

    logic drained;  // adder has taken the previous bank

    assign tile_end   = (count == tile_last);
    assign swap_ready = drained;

    always_ff @(posedge clk) begin
        if (reset) begin
            bank           <= 1'b0;
            count          <= '0;
            drained        <= 1'b1;
            pe_psum_finish <= 1'b0;
        end else if (clear) begin
            bank           <= 1'b0;
            count          <= '0;
            drained        <= 1'b1;  // nothing to drain at layer start
            pe_psum_finish <= 1'b0;
        end else begin
            pe_psum_finish <= swap;  // one pulse per bank hand-over
            if (swap) begin
                bank    <= ~bank;
                count   <= '0;
                drained <= 1'b0;     // old bank now waits for the adder
            end else begin
                if (su_done) begin
                    drained <= 1'b1;
                end
                if (advance && !tile_end) begin
                    count <= count + 1'b1;
                end
            end
        end
    end

endmodule

// ==== logic/rf_buffer_tracker.sv ====
// double buffer bookkeeping for one streamed operand, used once for actv and once for wgt
`timescale 1ns/1ps

module rf_buffer_tracker (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 clear,
    input  logic                 advance,
    input  logic                 swap,
    input  logic [1:0]           sent,
    input  pe_ctrl_pkg::tm_idx_t tile_last,
    output pe_ctrl_pkg::tm_idx_t count,
    output logic                 sel,
    output logic                 tile_end,
    output logic                 swap_ready,
    output logic [1:0]           need
);

    logic [1:0] loaded;       // buffer holds a full tile from the gbf
    logic [1:0] loaded_next;
    logic       active;       // set once a layer has started

    // counter parks at tile_last until the swap, so this holds through a stall
    assign tile_end   = (count == tile_last);
    assign swap_ready = loaded[~sel];  // next tile already in the other buffer
    assign need       = active ? ~loaded : 2'b00;

    // a strobe for a loaded buffer changes nothing
    always_comb begin
        loaded_next = loaded | sent;
        if (swap) begin
            loaded_next[sel] = 1'b0;  // finished buffer goes back for refill
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            loaded <= 2'b00;
            sel    <= 1'b0;
            count  <= '0;
        end else if (clear) begin
            active <= 1'b1;
            loaded <= 2'b00;
            sel    <= 1'b0;
            count  <= '0;
        end else begin
            loaded <= loaded_next;
            if (swap) begin
                sel   <= ~sel;
                count <= '0;
            end else if (advance && !tile_end) begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

// ==== logic/temporal_map.sv ====
// temporal mapping store, written through the config port and read once per issue into pe_ctrl
`timescale 1ns/1ps

module temporal_map (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cfg_wr,
    input  pe_ctrl_pkg::cfg_write_t cfg,
    input  logic                    advance,
    input  pe_ctrl_pkg::tm_idx_t    actv_idx,
    input  pe_ctrl_pkg::tm_idx_t    wgt_idx,
    input  pe_ctrl_pkg::tm_idx_t    psum_idx,
    input  logic                    actv_sel,
    input  logic                    wgt_sel,
    input  logic                    psum_bank,
    output pe_ctrl_pkg::tm_idx_t    actv_last,
    output pe_ctrl_pkg::tm_idx_t    wgt_last,
    output pe_ctrl_pkg::tm_idx_t    psum_last,
    output pe_ctrl_pkg::pe_ctrl_t   pe_ctrl
);

    // address sequences, one entry per issue within a tile
    logic [pe_ctrl_pkg::actv_addr_w-1:0] actv_tab [pe_ctrl_pkg::tm_depth];
    logic [pe_ctrl_pkg::wgt_addr_w-1:0]  wgt_tab  [pe_ctrl_pkg::tm_depth];
    logic [pe_ctrl_pkg::psum_addr_w-1:0] psum_tab [pe_ctrl_pkg::tm_depth];

    logic [pe_ctrl_pkg::pe_count-1:0] mac_mask;  // spatial unroll, same for every issue

    // host writes, only between layers
    always_ff @(posedge clk) begin
        if (cfg_wr) begin
            case (cfg.sel)
                pe_ctrl_pkg::cfg_tile_last: begin
                    case (pe_ctrl_pkg::operand_e'(cfg.index[1:0]))
                        pe_ctrl_pkg::op_actv: actv_last <= cfg.data[pe_ctrl_pkg::tm_idx_w-1:0];
                        pe_ctrl_pkg::op_wgt:  wgt_last <= cfg.data[pe_ctrl_pkg::tm_idx_w-1:0];
                        pe_ctrl_pkg::op_psum: psum_last <= cfg.data[pe_ctrl_pkg::tm_idx_w-1:0];
                        default: ;  // index 3 selects nothing
                    endcase
                end
                pe_ctrl_pkg::cfg_actv_addr: begin
                    actv_tab[cfg.index] <= cfg.data[pe_ctrl_pkg::actv_addr_w-1:0];
                end
                pe_ctrl_pkg::cfg_wgt_addr: begin
                    wgt_tab[cfg.index] <= cfg.data[pe_ctrl_pkg::wgt_addr_w-1:0];
                end
                pe_ctrl_pkg::cfg_psum_addr: begin
                    psum_tab[cfg.index] <= cfg.data[pe_ctrl_pkg::psum_addr_w-1:0];
                end
                pe_ctrl_pkg::cfg_mac_mask: begin
                    mac_mask <= cfg.data;
                end
                default: ;
            endcase
        end
    end

    // issue word, each operand looks up at its own counter
    always_ff @(posedge clk) begin
        if (reset) begin
            pe_ctrl <= '0;
        end else if (advance) begin
            pe_ctrl.mac_en    <= mac_mask;
            pe_ctrl.actv_sel  <= actv_sel;
            pe_ctrl.actv_addr <= actv_tab[actv_idx];
            pe_ctrl.wgt_sel   <= wgt_sel;
            pe_ctrl.wgt_addr  <= wgt_tab[wgt_idx];
            pe_ctrl.psum_bank <= psum_bank;
            pe_ctrl.psum_addr <= psum_tab[psum_idx];
        end else begin
            pe_ctrl <= '0;  // idle word, no mac and zero addresses
        end
    end

endmodule

// ==== logic/pe_ctrl_pkg.sv ====
// shared constants, enums and packed structs for the pe array controller and its testbench
package pe_ctrl_pkg;

    // pe array shape
    localparam int pe_rows = 4;
    localparam int pe_cols = 4;
    localparam int pe_count = pe_rows * pe_cols;  // one mac enable per pe

    // register file address widths
    localparam int actv_addr_w = 2;
    localparam int wgt_addr_w = 2;
    localparam int psum_addr_w = 2;

    // temporal mapping tables
    localparam int tm_depth = 16;
    localparam int tm_idx_w = 4;

    typedef logic [tm_idx_w-1:0] tm_idx_t;  // table index or tile counter

    typedef enum logic [1:0] {op_actv, op_wgt, op_psum} operand_e;

    // configuration target, index picks the operand for cfg_tile_last
    typedef enum logic [2:0] {
        cfg_tile_last,
        cfg_actv_addr,
        cfg_wgt_addr,
        cfg_psum_addr,
        cfg_mac_mask
    } cfg_sel_e;

    typedef enum logic [2:0] {st_idle, st_fill, st_compute, st_stall, st_swap, st_done} sched_state_e;

    typedef struct packed {
        cfg_sel_e sel;
        tm_idx_t index;
        logic [pe_count-1:0] data;
    } cfg_write_t;

    // one strobe per rf buffer, bit 0 is buffer 0
    typedef struct packed {
        logic [1:0] actv_sent;
        logic [1:0] wgt_sent;
    } gbf_sent_t;

    typedef struct packed {
        logic [1:0] actv_need;
        logic [1:0] wgt_need;
    } rf_need_t;

    typedef struct packed {
        logic [pe_count-1:0] mac_en;
        logic actv_sel;
        logic [actv_addr_w-1:0] actv_addr;
        logic wgt_sel;
        logic [wgt_addr_w-1:0] wgt_addr;
        logic psum_bank;
        logic [psum_addr_w-1:0] psum_addr;
    } pe_ctrl_t;

endpackage
